/* list.f */
+incdir+rtl
rtl/divTypesPkg.sv
rtl/divCtrlPkg.sv
rtl/divStepIf.sv
rtl/divOperandPrep.sv
rtl/divIterCounter.sv
rtl/divSequencer.sv
rtl/divShiftSub.sv
rtl/divSignFix.sv
rtl/divUnit.sv
tests/divUnitTb.sv

/* rtl/divCtrlPkg.sv */
// Divider control types, sequencer state encoding
package divCtrlPkg;

	// ====================
	// Sequencer states
	// ====================

	// Idle doubles as the done level
	// Iterate runs the shift-subtract steps
	// Fixup applies signs and writes results
	typedef enum logic [1:0] {
		Idle,
		Iterate,
		Fixup
	} divStateT;

endpackage

/* rtl/divIterCounter.sv */
// Divider step counter, counts iteration cycles and flags the final shift step
`include "divider_config.svh"

module divIterCounter (
	input logic clk,
	input logic rst,
	input logic ce,
	divStepIf.cnt ctl
);
	import divTypesPkg::*;

	stepCountT count;

	// ====================
	// Count
	// ====================

	// Cleared with the operands, then one tick per iteration cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (ce) begin
			if (ctl.start) begin
				count <= '0;
			end else if (ctl.step) begin
				count <= count + stepCountT'(1);
			end
		end
	end

	// Final step decode
	// first iteration cycle loads the datapath, so this lands one short of the end
	assign ctl.lastStep = (count == stepCountT'(`DIV_WID - 1));

endmodule

/* rtl/divOperandPrep.sv */
// Divider operand prep, divisor select, magnitudes, sign capture and zero detect
`include "divider_config.svh"

module divOperandPrep (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic su,
	input logic ri,
	input divTypesPkg::dividendT a,
	input divTypesPkg::divisorT b,
	input divTypesPkg::divisorT i,
	output divTypesPkg::dividendT aMag,
	output divTypesPkg::divisorT bMag,
	output logic aNeg,
	output logic bNeg,
	divStepIf.prep ctl
);
	import divTypesPkg::*;

	divisorT bSel;
	dividendT aAbs;
	divisorT bAbs;
	logic aSign;
	logic bSign;

	// Register port when ri is set, immediate otherwise
	assign bSel = ri ? b : i;

	// Zero test on the selected divisor, seen by sequencer in the start cycle
	assign ctl.zeroDiv = (bSel == '0);

	// Signs only count in signed mode
	assign aSign = su & a[`DIV_WID-1];
	assign bSign = su & bSel[`DIV_HWID-1];

	// Two's complement magnitudes
	// -2^31 stays 0x8000_0000, read as unsigned
	assign aAbs = aSign ? -a : a;
	assign bAbs = bSign ? -bSel : bSel;

	// Sign flags for the fixup stage
	always_ff @(posedge clk) begin
		if (rst) begin
			aNeg <= 1'b0;
			bNeg <= 1'b0;
		end else if (ce && ctl.start) begin
			aNeg <= aSign;
			bNeg <= bSign;
		end
	end

	// Magnitudes, captured once per division
	always_ff @(posedge clk) begin
		if (ce && ctl.start) begin
			aMag <= aAbs;
			bMag <= bAbs;
		end
	end

endmodule

/* rtl/divSequencer.sv */
// Divider sequencer FSM, load, iterate, sign fixup and the done level
module divSequencer (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic ld,
	output logic done,
	divStepIf.seq ctl
);
	import divCtrlPkg::*;

	divStateT state;
	divStateT stateNext;
	// Last step seen on the previous edge
	logic lastSeen;

	// ====================
	// Strobes
	// ====================

	// ld only counts when idle and enabled
	assign ctl.start = ce & ld & (state == Idle);
	assign ctl.step = (state == Iterate);
	assign ctl.finish = (state == Fixup);

	// Done is simply the idle state
	assign done = (state == Idle);

	// ====================
	// Next state
	// ====================

	always_comb begin
		stateNext = state;
		case (state)
			Idle: begin
				// Zero divisor is resolved in the start cycle itself
				if (ctl.start && !ctl.zeroDiv) begin
					stateNext = Iterate;
				end
			end
			Iterate: begin
				// One more cycle after the counter's final step
				if (lastSeen) begin
					stateNext = Fixup;
				end
			end
			Fixup: stateNext = Idle;
			default: stateNext = Idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= Idle;
			lastSeen <= 1'b0;
		end else if (ce) begin
			state <= stateNext;
			lastSeen <= ctl.step & ctl.lastStep;
		end
	end

endmodule

/* rtl/divShiftSub.sv */
// Divider datapath, restoring shift-subtract with partial remainder and quotient shifter
`include "divider_config.svh"

module divShiftSub (
	input logic clk,
	input logic rst,
	input logic ce,
	input divTypesPkg::dividendT aMag,
	input divTypesPkg::divisorT bMag,
	output divTypesPkg::quotientT qRaw,
	output divTypesPkg::remainderT rRaw,
	divStepIf.data ctl
);
	import divTypesPkg::*;

	partialT rem;
	partialT shifted;
	quotientT quo;
	// Trial difference, top bit is the borrow
	logic [`DIV_HWID+1:0] trial;
	logic borrow;
	// Operands still to be loaded from prep
	logic loadPend;

	// Next dividend bit enters from the quotient MSB
	assign shifted = {rem[`DIV_HWID-1:0], quo[`DIV_WID-1]};
	assign trial = {1'b0, shifted} - {2'b00, bMag};
	assign borrow = trial[`DIV_HWID+1];

	// Prep registers on start, so the load waits for the first step
	always_ff @(posedge clk) begin
		if (rst) begin
			loadPend <= 1'b0;
		end else if (ce) begin
			if (ctl.start) begin
				loadPend <= 1'b1;
			end else if (ctl.step) begin
				loadPend <= 1'b0;
			end
		end
	end

	// ====================
	// Shift and subtract
	// ====================

	always_ff @(posedge clk) begin
		if (ce && ctl.step) begin
			if (loadPend) begin
				quo <= aMag;
				rem <= '0;
			end else begin
				// Quotient bit is the inverted borrow
				quo <= {quo[`DIV_WID-2:0], ~borrow};
				// Restore on borrow
				rem <= borrow ? shifted : trial[`DIV_HWID:0];
			end
		end
	end

	assign qRaw = quo;
	// Final remainder is below the divisor, guard bit is clear
	assign rRaw = rem[`DIV_HWID-1:0];

endmodule

/* rtl/divSignFix.sv */
// Divider result stage, sign correction or divide-by-zero result into the output registers
module divSignFix (
	input logic clk,
	input logic rst,
	input logic ce,
	input divTypesPkg::quotientT qRaw,
	input divTypesPkg::remainderT rRaw,
	input logic aNeg,
	input logic bNeg,
	output divTypesPkg::quotientT q,
	output divTypesPkg::remainderT r,
	output logic divByZero,
	divStepIf.data ctl,
	input logic zeroDiv
);
	// Quotient negative when operand signs differ
	logic qNeg;

	assign qNeg = aNeg ^ bNeg;

	// ====================
	// Result registers
	// ====================

	// Results hold until the next accepted load
	always_ff @(posedge clk) begin
		if (rst) begin
			q <= '0;
			r <= '0;
			divByZero <= 1'b0;
		end else if (ce) begin
			if (ctl.start && zeroDiv) begin
				// No iteration, fixed result on the load edge
				q <= '1;
				r <= '0;
				divByZero <= 1'b1;
			end else if (ctl.finish) begin
				q <= qNeg ? -qRaw : qRaw;
				// Remainder follows the dividend sign
				r <= aNeg ? -rRaw : rRaw;
				divByZero <= 1'b0;
			end
		end
	end

endmodule

/* rtl/divStepIf.sv */
// Divider step control bundle between sequencer, step counter and datapath blocks
interface divStepIf;

	// Operands accepted, single cycle
	logic start;
	// High for every iteration cycle
	logic step;
	// Single cycle in Fixup, results written
	logic finish;
	// Counter at its final step
	logic lastStep;
	// Selected divisor is zero
	logic zeroDiv;

	// ====================
	// Views
	// ====================

	// Sequencer owns the strobes
	modport seq (output start, step, finish, input lastStep, zeroDiv);

	// Step counter
	modport cnt (input start, step, output lastStep);

	// Operand prep flags the zero divisor
	modport prep (input start, output zeroDiv);

	// Datapath and result blocks only listen
	modport data (input start, step, finish);

endinterface

/* rtl/divTypesPkg.sv */
// Divider datapath types, operand, result and step count vectors
`include "divider_config.svh"

package divTypesPkg;

	// ====================
	// Operands
	// ====================

	// Dividend, raw value or magnitude
	typedef logic [`DIV_WID-1:0] dividendT;
	// Divisor, register or immediate
	typedef logic [`DIV_HWID-1:0] divisorT;

	// ====================
	// Results
	// ====================

	typedef logic [`DIV_WID-1:0] quotientT;
	typedef logic [`DIV_HWID-1:0] remainderT;
	// Partial remainder, one guard bit for the shift before subtract
	typedef logic [`DIV_HWID:0] partialT;

	// Iteration index
	typedef logic [`DIV_CNT_W-1:0] stepCountT;

endpackage

/* rtl/divUnit.sv */
// Sequential radix-2 restoring divider top, 32 by 16 bit signed or unsigned
module divUnit (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic ld,
	input logic su,
	input logic ri,
	input divTypesPkg::dividendT a,
	input divTypesPkg::divisorT b,
	input divTypesPkg::divisorT i,
	output divTypesPkg::quotientT q,
	output divTypesPkg::remainderT r,
	output logic divByZero,
	output logic done
);
	import divTypesPkg::*;

	// Prep to datapath and result stage
	dividendT aMag;
	divisorT bMag;
	logic aNeg;
	logic bNeg;
	// Datapath to result stage
	quotientT qRaw;
	remainderT rRaw;

	// ====================
	// Control
	// ====================

	divStepIf ctl ();

	divSequencer u_seq (
		.clk(clk), .rst(rst), .ce(ce), .ld(ld), .done(done), .ctl(ctl.seq)
	);

	divIterCounter u_cnt (.clk(clk), .rst(rst), .ce(ce), .ctl(ctl.cnt));

	// ====================
	// Datapath
	// ====================

	divOperandPrep u_prep (
		.clk(clk), .rst(rst), .ce(ce), .su(su), .ri(ri),
		.a(a), .b(b), .i(i),
		.aMag(aMag), .bMag(bMag), .aNeg(aNeg), .bNeg(bNeg),
		.ctl(ctl.prep)
	);

	divShiftSub u_shift (
		.clk(clk), .rst(rst), .ce(ce), .aMag(aMag), .bMag(bMag),
		.qRaw(qRaw), .rRaw(rRaw), .ctl(ctl.data)
	);

	// Zero flag goes around the data view
	divSignFix u_fix (
		.clk(clk), .rst(rst), .ce(ce), .qRaw(qRaw), .rRaw(rRaw),
		.aNeg(aNeg), .bNeg(bNeg), .q(q), .r(r), .divByZero(divByZero),
		.ctl(ctl.data), .zeroDiv(ctl.zeroDiv)
	);

endmodule

/* rtl/divider_config.svh */
// Divider width configuration, quotient and remainder sizes plus step counter width
`ifndef DIVIDER_CONFIG_SVH
`define DIVIDER_CONFIG_SVH

// ====================
// Operand widths
// ====================

// Dividend and quotient width
`define DIV_WID 32

// Divisor and remainder, half the dividend
`define DIV_HWID (`DIV_WID / 2)

// ====================
// Sequencing
// ====================

// Step counter width, must hold DIV_WID + 1
`define DIV_CNT_W 6

`endif

/* run.sh */
#!/bin/sh
# Build and run the divider testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f list.f --top-module divUnitTb -o divUnitSim \
	&& ./obj_dir/divUnitSim > sim.log 2>&1 \
	|| echo "build or simulation ended with an error"
grep -q "TESTBENCH PASSED" sim.log && echo "run ok" || { echo "run failed"; exit 1; }

/* tests/divUnitTb.sv */
// Divider testbench driven from file vectors with fixed and random clock enable
`include "divider_config.svh"

module divUnitTb;
	import divTypesPkg::*;

	localparam int PERIOD = 100;
	localparam logic [31:0] SEED = 32'hc1b9_ea1f;
	// Spare cycles on top of the run estimate
	localparam int MARGIN = 200;

	logic clk;
	logic rst;
	logic ce;
	logic ld;
	logic su;
	logic ri;
	dividendT a;
	divisorT b;
	divisorT i;
	quotientT q;
	remainderT r;
	logic divByZero;
	logic done;

	// One queue per file column
	logic vecSu[$];
	logic vecRi[$];
	dividendT vecA[$];
	divisorT vecB[$];
	divisorT vecI[$];
	quotientT vecQ[$];
	remainderT vecR[$];
	logic vecDz[$];

	logic [31:0] lcgState;
	bit loaded;

	divUnit u_dut (
		.clk(clk), .rst(rst), .ce(ce), .ld(ld), .su(su), .ri(ri),
		.a(a), .b(b), .i(i), .q(q), .r(r), .divByZero(divByZero), .done(done)
	);

	always #(PERIOD / 2) clk = ~clk;

	// ====================
	// Helpers
	// ====================

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Enable high about three cycles in four when random
	task automatic driveCe(input bit useRandom);
		if (useRandom) begin
			lcgState = lcgNext(lcgState);
			ce = (lcgState[31:30] != 2'b00);
		end else begin
			ce = 1'b1;
		end
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, expected);
			$display("TESTBENCH FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic loadVectors();
		int fd;
		int code;
		int badLines;
		string line;
		logic suV;
		logic riV;
		dividendT aV;
		divisorT bV;
		divisorT iV;
		quotientT qV;
		remainderT rV;
		logic dzV;
		badLines = 0;
		fd = $fopen("tests/divUnit_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test data file");
			$display("TESTBENCH FAILED");
			$fatal(1, "missing test data");
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				// Skip blank and comment lines
				if (code > 1 && line.getc(0) != "#") begin
					code = $sscanf(line, "%h %h %h %h %h %h %h %h",
						suV, riV, aV, bV, iV, qV, rV, dzV);
					if (code != 8) begin
						badLines++;
					end else begin
						vecSu.push_back(suV);
						vecRi.push_back(riV);
						vecA.push_back(aV);
						vecB.push_back(bV);
						vecI.push_back(iV);
						vecQ.push_back(qV);
						vecR.push_back(rV);
						vecDz.push_back(dzV);
					end
				end
			end
			$fclose(fd);
			if (badLines != 0 || vecA.size() == 0) begin
				$display("Test data file has %0d unreadable lines or no vectors", badLines);
				$display("TESTBENCH FAILED");
				$fatal(1, "bad test data");
			end
		end
	endtask

	// ====================
	// One division
	// ====================

	// Called and returns on a falling edge
	task automatic runDivision(input int idx, input bit useRandom, input bit injectLd);
		int edges;
		bit accepted;
		su = vecSu[idx];
		ri = vecRi[idx];
		a = vecA[idx];
		b = vecB[idx];
		i = vecI[idx];
		ld = 1'b1;
		accepted = 1'b0;
		// Hold ld until an enabled edge takes it
		while (!accepted) begin
			driveCe(useRandom);
			@(posedge clk);
			accepted = ce;
			@(negedge clk);
		end
		ld = 1'b0;
		edges = 0;
		if (vecDz[idx]) begin
			// Zero divisor skips the iteration
			checkValue("done", 32'(done), 32'd1);
		end else begin
			checkValue("done", 32'(done), 32'd0);
			while (!done) begin
				// Busy ld pulse with a zero divisor must be ignored
				if (injectLd && edges == 5) begin
					a = 32'h0000_0001;
					b = 16'h0000;
					i = 16'h0000;
					ld = 1'b1;
				end else begin
					ld = 1'b0;
				end
				driveCe(useRandom);
				@(negedge clk);
				if (ce) begin
					edges++;
				end
			end
			ld = 1'b0;
			// Enabled edges after acceptance up to done
			checkValue("latency", 32'(edges), 32'(`DIV_WID + 2));
		end
		checkValue("q", q, vecQ[idx]);
		checkValue("r", 32'(r), 32'(vecR[idx]));
		checkValue("divByZero", 32'(divByZero), 32'(vecDz[idx]));
		if (useRandom) begin
			// Frozen clock enable with a pending ld
			ce = 1'b0;
			ld = 1'b1;
			a = ~a;
			repeat (3) @(negedge clk);
			checkValue("q", q, vecQ[idx]);
			checkValue("r", 32'(r), 32'(vecR[idx]));
			checkValue("divByZero", 32'(divByZero), 32'(vecDz[idx]));
			checkValue("done", 32'(done), 32'd1);
			ld = 1'b0;
		end
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		int busyIdx;
		clk = 1'b0;
		rst = 1'b1;
		ce = 1'b1;
		ld = 1'b0;
		su = 1'b0;
		ri = 1'b0;
		a = '0;
		b = '0;
		i = '0;
		lcgState = SEED;
		loadVectors();
		loaded = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// Reset state
		checkValue("done", 32'(done), 32'd1);
		checkValue("divByZero", 32'(divByZero), 32'd0);
		checkValue("q", q, 32'd0);
		checkValue("r", 32'(r), 32'd0);
		// Enable held high
		for (int n = 0; n < vecA.size(); n++) begin
			runDivision(n, 1'b0, 1'b0);
		end
		// First vector with a real divisor
		busyIdx = 0;
		while (busyIdx < vecA.size() - 1 && vecDz[busyIdx]) begin
			busyIdx++;
		end
		runDivision(busyIdx, 1'b0, 1'b1);
		// Enable from the LCG
		for (int n = 0; n < vecA.size(); n++) begin
			runDivision(n, 1'b1, 1'b0);
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

	// Both passes plus the busy run, x4 for enable gaps
	initial begin
		int limit;
		wait (loaded);
		limit = ((2 * vecA.size() + 1) * (`DIV_WID + 7) * 4 + MARGIN) * PERIOD;
		#(limit);
		$display("Timeout after %0d time units because the divider never finished", limit);
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

/* tests/divUnit_testdata.txt */
# su ri a b i then expected q r divByZero
# All fields in hex and ri set selects b over i
0 1 00000064 0007 0000 0000000e 0002 0
0 0 ffffffff 0000 ffff 00010001 0000 0
0 1 12345678 1234 0001 00010004 0da8 0
0 0 00000005 1111 0009 00000000 0005 0
0 1 80000000 8000 0000 00010000 0000 0
0 1 deadbeef 0001 0000 deadbeef 0000 0
0 0 ffffffff 0000 0010 0fffffff 000f 0
1 1 ffffff9c 0007 0000 fffffff2 fffe 0
1 0 00000064 0000 fff9 fffffff2 0002 0
1 1 ffffff9c fff9 0000 0000000e fffe 0
1 1 80000000 ffff 0000 80000000 0000 0
1 0 80000000 0000 8000 00010000 0000 0
1 1 00012345 8000 0000 fffffffe 2345 0
1 1 7fffffff 7fff 0000 00010002 0001 0
1 0 fffffff9 0000 0002 fffffffd ffff 0
1 1 00000003 fffc 0000 00000000 0003 0
0 1 12345678 0000 0005 ffffffff 0000 1
1 0 ffffff9c 0003 0000 ffffffff 0000 1
0 0 00000064 0000 000a 0000000a 0000 0
0 1 00010000 0003 0000 00005555 0001 0
1 1 fffffffe 0001 0000 fffffffe 0000 0
0 1 00000000 0005 0000 00000000 0000 0
